// File: filelist.f
hw/core_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core_top.sv
bench/core_assertions.sv
bench/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds core_tb with Verilator and runs it, result taken from sim.log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --top-module core_tb -f filelist.f -o core_sim > build.log 2>&1 &&
./obj_dir/core_sim > sim.log 2>&1 ||
echo "build or simulation ended with an error, see build.log and sim.log"
grep -qx '>>> PASS' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: bench/core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module core_tb
    import core_pkg::*;
();

    localparam int num_tests   = 5;
    localparam int max_inst    = 12;
    localparam int max_events  = 12;
    localparam int cycle_limit = num_tests * 80;

    // base words of the kept instructions, fields zero
    localparam word_t inst_add_w   = 32'h00100000;
    localparam word_t inst_sub_w   = 32'h00110000;
    localparam word_t inst_slt     = 32'h00120000;
    localparam word_t inst_sltu    = 32'h00128000;
    localparam word_t inst_and     = 32'h00148000;
    localparam word_t inst_or      = 32'h00150000;
    localparam word_t inst_xor     = 32'h00158000;
    localparam word_t inst_addi_w  = 32'h02800000;
    localparam word_t inst_lu12i_w = 32'h14000000;
    localparam word_t inst_ld_b    = 32'h28000000;
    localparam word_t inst_ld_w    = 32'h28800000;
    localparam word_t inst_st_b    = 32'h29000000;
    localparam word_t inst_st_w    = 32'h29800000;
    localparam word_t inst_ld_bu   = 32'h2a000000;
    localparam word_t inst_b       = 32'h50000000;
    localparam word_t inst_bl      = 32'h54000000;
    localparam word_t inst_beq     = 32'h58000000;
    localparam word_t inst_bne     = 32'h5c000000;

    logic      clk;
    logic      reset;
    word_t     inst_addr;
    word_t     inst_rdata;
    logic      data_en;
    strobe_t   data_we;
    word_t     data_addr;
    word_t     data_wdata;
    word_t     data_rdata = '0;
    word_t     debug_wb_pc;
    logic      debug_wb_rf_we;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;

    // program table with one row per test
    string     test_name [num_tests];
    word_t     prog      [num_tests][max_inst];
    int        prog_len  [num_tests];
    reg_addr_t exp_rd    [num_tests][max_events];
    word_t     exp_val   [num_tests][max_events];
    word_t     exp_pc    [num_tests][max_events];
    int        exp_gap   [num_tests][max_events];  // cycles since the previous event or 0 for any
    int        exp_len   [num_tests];

    word_t      imem [64];
    word_t      dmem [64];
    word_t      fetch_offset;
    logic       port_en;
    strobe_t    port_we;
    logic [5:0] port_index;
    word_t      port_wdata;

    reg_addr_t got_rd [$];
    word_t     got_val [$];
    word_t     got_pc [$];
    int        got_cycle [$];
    logic      capture;
    int        cycle_count = 0;
    int        value_errors = 0;
    int        event_errors = 0;
    int        assert_failures;

    core_top u_core_top
    (
        .clk               (clk),
        .reset             (reset),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .data_en           (data_en),
        .data_we           (data_we),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_rdata        (data_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    bind core_top core_assertions u_core_assertions
    (
        .clk              (clk),
        .reset            (reset),
        .data_en          (data_en),
        .data_we          (data_we),
        .data_addr        (data_addr),
        .debug_wb_rf_we   (debug_wb_rf_we),
        .debug_wb_rf_wnum (debug_wb_rf_wnum)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign fetch_offset = inst_addr - reset_pc;
    assign inst_rdata   = imem[fetch_offset[7:2]];  // combinational fetch

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e3779b1) ^ 32'h5a5a5a5a;
    endfunction

    // sram port answers 2 ns after the edge that takes the request
    always @(posedge clk)
    begin
        port_en    = data_en;
        port_we    = data_we;
        port_index = data_addr[7:2];
        port_wdata = data_wdata;
        #2;
        if (!reset)
        begin
            for (int i = 0; i < 64; i++)
                dmem[i] = fill_word(word_t'(i * 4));
        end
        else if (port_en)
        begin
            for (int lane = 0; lane < 4; lane++)
                if (port_we[lane])
                    dmem[port_index][lane*8 +: 8] = port_wdata[lane*8 +: 8];
            data_rdata = dmem[port_index];
        end
    end

    always @(negedge clk)
    begin
        if (capture && debug_wb_rf_we)
        begin
            got_rd.push_back(debug_wb_rf_wnum);
            got_val.push_back(debug_wb_rf_wdata);
            got_pc.push_back(debug_wb_pc);
            got_cycle.push_back(cycle_count);
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("run stopped: cycle limit of %0d reached", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic word_t reg3(input word_t base, input reg_addr_t rd,
                                   input reg_addr_t rj, input reg_addr_t rk);
        return base | {17'b0, rk, rj, rd};
    endfunction

    function automatic word_t imm12(input word_t base, input reg_addr_t rd,
                                    input reg_addr_t rj, input logic [11:0] imm);
        return base | {10'b0, imm, rj, rd};
    endfunction

    function automatic word_t upper20(input reg_addr_t rd, input logic [19:0] si20);
        return inst_lu12i_w | {7'b0, si20, rd};
    endfunction

    // offsets are in words
    function automatic word_t cond_branch(input word_t base, input reg_addr_t rj,
                                          input reg_addr_t rd, input logic [15:0] words);
        return base | {6'b0, words, rj, rd};
    endfunction

    function automatic word_t jump(input word_t base, input logic [25:0] words);
        return base | {6'b0, words[15:0], words[25:16]};
    endfunction

    task automatic put_inst(input int t, input word_t inst);
        prog[t][prog_len[t]] = inst;
        prog_len[t]++;
    endtask

    // idx is the program slot of the writing instruction
    task automatic put_event(input int t, input int idx, input reg_addr_t rd,
                             input word_t value, input int gap);
        exp_rd[t][exp_len[t]]  = rd;
        exp_val[t][exp_len[t]] = value;
        exp_pc[t][exp_len[t]]  = reset_pc + word_t'(idx * 4);
        exp_gap[t][exp_len[t]] = gap;
        exp_len[t]++;
    endtask

    task automatic build_table();
        for (int t = 0; t < num_tests; t++)
        begin
            prog_len[t] = 0;
            exp_len[t]  = 0;
        end

        test_name[0] = "alu_imm";
        put_inst(0, upper20(5'd4, 20'h12345));
        put_inst(0, imm12(inst_addi_w, 5'd4, 5'd4, 12'h678));
        put_inst(0, imm12(inst_addi_w, 5'd5, 5'd0, 12'hfff));
        put_inst(0, reg3(inst_add_w, 5'd6, 5'd4, 5'd5));
        put_inst(0, reg3(inst_sub_w, 5'd7, 5'd4, 5'd5));
        put_inst(0, reg3(inst_and, 5'd8, 5'd4, 5'd6));
        put_inst(0, reg3(inst_or, 5'd9, 5'd4, 5'd6));
        put_inst(0, reg3(inst_xor, 5'd10, 5'd4, 5'd6));
        put_inst(0, reg3(inst_slt, 5'd11, 5'd5, 5'd4));
        put_inst(0, reg3(inst_sltu, 5'd12, 5'd5, 5'd4));
        put_inst(0, imm12(inst_addi_w, 5'd0, 5'd4, 12'h001));  // r0 write gives no event
        put_inst(0, jump(inst_b, 26'd0));
        put_event(0, 0, 5'd4, 32'h12345000, 0);
        put_event(0, 1, 5'd4, 32'h12345678, 1);
        put_event(0, 2, 5'd5, 32'hffffffff, 1);
        put_event(0, 3, 5'd6, 32'h12345677, 1);
        put_event(0, 4, 5'd7, 32'h12345679, 1);
        put_event(0, 5, 5'd8, 32'h12345670, 1);
        put_event(0, 6, 5'd9, 32'h1234567f, 1);
        put_event(0, 7, 5'd10, 32'h0000000f, 1);
        put_event(0, 8, 5'd11, 32'h00000001, 1);
        put_event(0, 9, 5'd12, 32'h00000000, 1);

        test_name[1] = "forwarding";
        put_inst(1, imm12(inst_addi_w, 5'd1, 5'd0, 12'h005));
        put_inst(1, reg3(inst_add_w, 5'd2, 5'd1, 5'd1));
        put_inst(1, reg3(inst_add_w, 5'd3, 5'd2, 5'd1));
        put_inst(1, reg3(inst_add_w, 5'd4, 5'd3, 5'd2));
        put_inst(1, reg3(inst_add_w, 5'd5, 5'd4, 5'd3));
        put_inst(1, reg3(inst_add_w, 5'd6, 5'd5, 5'd3));  // r3 via write-through read
        put_inst(1, jump(inst_b, 26'd0));
        put_event(1, 0, 5'd1, 32'd5, 0);
        put_event(1, 1, 5'd2, 32'd10, 1);
        put_event(1, 2, 5'd3, 32'd15, 1);
        put_event(1, 3, 5'd4, 32'd25, 1);
        put_event(1, 4, 5'd5, 32'd40, 1);
        put_event(1, 5, 5'd6, 32'd55, 1);

        test_name[2] = "load_store";
        put_inst(2, upper20(5'd2, 20'h11223));
        put_inst(2, imm12(inst_addi_w, 5'd2, 5'd2, 12'h344));
        put_inst(2, imm12(inst_st_w, 5'd2, 5'd0, 12'h020));
        put_inst(2, imm12(inst_addi_w, 5'd1, 5'd0, 12'h080));
        put_inst(2, imm12(inst_st_b, 5'd1, 5'd0, 12'h021));  // lane 1 only
        put_inst(2, imm12(inst_ld_w, 5'd3, 5'd0, 12'h020));
        put_inst(2, imm12(inst_ld_b, 5'd4, 5'd0, 12'h021));
        put_inst(2, imm12(inst_ld_bu, 5'd5, 5'd0, 12'h021));
        put_inst(2, jump(inst_b, 26'd0));
        put_event(2, 0, 5'd2, 32'h11223000, 0);
        put_event(2, 1, 5'd2, 32'h11223344, 1);
        put_event(2, 3, 5'd1, 32'h00000080, 0);
        put_event(2, 5, 5'd3, 32'h11228044, 0);
        put_event(2, 6, 5'd4, 32'hffffff80, 1);
        put_event(2, 7, 5'd5, 32'h00000080, 1);

        test_name[3] = "load_use";
        put_inst(3, imm12(inst_addi_w, 5'd1, 5'd0, 12'h07b));
        put_inst(3, imm12(inst_st_w, 5'd1, 5'd0, 12'h030));
        put_inst(3, imm12(inst_ld_w, 5'd2, 5'd0, 12'h030));
        put_inst(3, reg3(inst_add_w, 5'd3, 5'd2, 5'd1));
        put_inst(3, imm12(inst_ld_w, 5'd4, 5'd0, 12'h030));
        put_inst(3, reg3(inst_sub_w, 5'd5, 5'd0, 5'd4));
        put_inst(3, jump(inst_b, 26'd0));
        put_event(3, 0, 5'd1, 32'h0000007b, 0);
        put_event(3, 2, 5'd2, 32'h0000007b, 0);
        put_event(3, 3, 5'd3, 32'h000000f6, 2);  // one slot lost to the stall
        put_event(3, 4, 5'd4, 32'h0000007b, 1);
        put_event(3, 5, 5'd5, 32'hffffff85, 2);

        test_name[4] = "branches";
        put_inst(4, imm12(inst_addi_w, 5'd1, 5'd0, 12'h003));
        put_inst(4, imm12(inst_addi_w, 5'd2, 5'd0, 12'h003));
        put_inst(4, cond_branch(inst_bne, 5'd1, 5'd2, 16'd3));  // not taken, index 5 if it were
        put_inst(4, cond_branch(inst_beq, 5'd1, 5'd2, 16'd3));  // to index 6
        put_inst(4, imm12(inst_addi_w, 5'd3, 5'd0, 12'h001));
        put_inst(4, imm12(inst_addi_w, 5'd4, 5'd0, 12'h002));
        put_inst(4, imm12(inst_addi_w, 5'd5, 5'd0, 12'h007));
        put_inst(4, jump(inst_bl, 26'd3));                     // to index 10
        put_inst(4, imm12(inst_addi_w, 5'd6, 5'd0, 12'h001));
        put_inst(4, imm12(inst_addi_w, 5'd7, 5'd0, 12'h001));
        put_inst(4, imm12(inst_addi_w, 5'd8, 5'd1, 12'h000));
        put_inst(4, jump(inst_b, 26'd0));
        put_event(4, 0, 5'd1, 32'h00000003, 0);
        put_event(4, 1, 5'd2, 32'h00000003, 1);
        put_event(4, 6, 5'd5, 32'h00000007, 0);
        put_event(4, 7, 5'd1, 32'h1c000020, 0);
        put_event(4, 10, 5'd8, 32'h1c000020, 0);
    endtask

    task automatic check_trace(input int t, input int first);
        int seen;
        int n;
        int gap;
        seen = got_rd.size() - first;
        if (seen != exp_len[t])
        begin
            $display("test %s: expected %0d trace events but saw %0d",
                     test_name[t], exp_len[t], seen);
            event_errors++;
        end
        n = (seen < exp_len[t]) ? seen : exp_len[t];
        for (int e = 0; e < n; e++)
        begin
            if (got_rd[first+e] != exp_rd[t][e])
            begin
                $display("[ERROR] %s event %0d register: expected %0d, actual %0d",
                         test_name[t], e, exp_rd[t][e], got_rd[first+e]);
                value_errors++;
            end
            if (got_val[first+e] != exp_val[t][e])
            begin
                $display("[ERROR] %s event %0d value: expected %h, actual %h",
                         test_name[t], e, exp_val[t][e], got_val[first+e]);
                value_errors++;
            end
            if (got_pc[first+e] != exp_pc[t][e])
            begin
                $display("[ERROR] %s event %0d pc: expected %h, actual %h",
                         test_name[t], e, exp_pc[t][e], got_pc[first+e]);
                value_errors++;
            end
            if (exp_gap[t][e] != 0 && e > 0)
            begin
                gap = got_cycle[first+e] - got_cycle[first+e-1];
                if (gap != exp_gap[t][e])
                begin
                    $display("[ERROR] %s event %0d spacing: expected %0d, actual %0d",
                             test_name[t], e, exp_gap[t][e], gap);
                    value_errors++;
                end
            end
        end
    endtask

    task automatic run_test(input int t);
        int first;
        @(posedge clk);
        #2;
        reset   = 1'b0;
        capture = 1'b0;
        for (int i = 0; i < 64; i++)
            imem[i] = '0;
        for (int i = 0; i < prog_len[t]; i++)
            imem[i] = prog[t][i];
        first = got_rd.size();
        repeat (10) @(posedge clk);
        #2;
        reset   = 1'b1;
        capture = 1'b1;
        repeat (60) @(posedge clk);
        capture = 1'b0;
        check_trace(t, first);
    endtask

    initial
    begin
        reset   = 1'b0;
        capture = 1'b0;
        build_table();
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        assert_failures = u_core_top.u_core_assertions.fail_count;
        $display("value errors %0d, event count errors %0d, assertion failures %0d",
                 value_errors, event_errors, assert_failures);
        if (value_errors == 0 && event_errors == 0 && assert_failures == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/core_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module core_assertions import core_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      data_en,
    input strobe_t   data_we,
    input word_t     data_addr,
    input logic      debug_wb_rf_we,
    input reg_addr_t debug_wb_rf_wnum
);

    int fail_count = 0;  // read back by the testbench

    we_needs_en: assert property (@(posedge clk) disable iff (!reset)
        data_we != '0 |-> data_en)
    else
    begin
        $error("data_we set while data_en is low");
        fail_count++;
    end

    no_r0_trace: assert property (@(posedge clk) disable iff (!reset)
        debug_wb_rf_we |-> debug_wb_rf_wnum != '0)
    else
    begin
        $error("trace port reports a write to r0");
        fail_count++;
    end

    word_store_aligned: assert property (@(posedge clk) disable iff (!reset)
        data_en && data_we == 4'hf |-> data_addr[1:0] == 2'b00)
    else
    begin
        $error("word store to an unaligned address");
        fail_count++;
    end

    // first writeback needs four cycles of pipeline fill
    quiet_after_reset: assert property (@(posedge clk) disable iff (!reset)
        debug_wb_rf_we |-> $past(reset, 1) && $past(reset, 2) && $past(reset, 3)
                           && $past(reset, 4))
    else
    begin
        $error("register write within four cycles of reset release");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: hw/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    output word_t     inst_addr,
    input  word_t     inst_rdata,
    output logic      data_en,
    output strobe_t   data_we,
    output word_t     data_addr,
    output word_t     data_wdata,
    input  word_t     data_rdata,
    output word_t     debug_wb_pc,
    output logic      debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       wb;
    redirect_t redirect;
    logic      stall;
    reg_addr_t ex_load_rd;

    fetch_stage u_fetch_stage
    (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .redirect   (redirect),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .if_id      (if_id)
    );

    decode_stage u_decode_stage
    (
        .clk        (clk),
        .reset      (reset),
        .if_id      (if_id),
        .wb         (wb),
        .redirect   (redirect),
        .ex_load_rd (ex_load_rd),
        .stall      (stall),
        .id_ex      (id_ex)
    );

    execute_stage u_execute_stage
    (
        .clk        (clk),
        .reset      (reset),
        .id_ex      (id_ex),
        .wb         (wb),
        .redirect   (redirect),
        .ex_load_rd (ex_load_rd),
        .data_en    (data_en),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .ex_mem     (ex_mem)
    );

    memory_stage u_memory_stage
    (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .data_rdata (data_rdata),
        .wb         (wb)
    );

    // trace port taps the writeback bus
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_we    = wb.we;
    assign debug_wb_rf_wnum  = wb.rd;
    assign debug_wb_rf_wdata = wb.data;

endmodule

`default_nettype wire

// File: hw/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

module memory_stage import core_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  ex_mem_t ex_mem,
    input  word_t   data_rdata,
    output wb_t     wb
);

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     alu_result;
        word_t     load_data;
        wb_sel_t   wb_sel;
        logic      reg_we;
    } mem_wb_t;

    logic [7:0] load_byte;
    word_t      load_data;
    word_t      wb_data;
    mem_wb_t    mem_wb;

    always_comb
    begin
        case (ex_mem.alu_result[1:0])  // byte lane from the address
            2'd0:    load_byte = data_rdata[7:0];
            2'd1:    load_byte = data_rdata[15:8];
            2'd2:    load_byte = data_rdata[23:16];
            default: load_byte = data_rdata[31:24];
        endcase
    end

    always_comb
    begin
        case (ex_mem.mem_op)
            mem_ld_b:  load_data = {{24{load_byte[7]}}, load_byte};
            mem_ld_bu: load_data = {24'b0, load_byte};
            default:   load_data = data_rdata;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
            mem_wb <= '0;
        else
            mem_wb <= '{
                valid:      ex_mem.valid,
                pc:         ex_mem.pc,
                rd:         ex_mem.rd,
                alu_result: ex_mem.alu_result,
                load_data:  load_data,
                wb_sel:     ex_mem.wb_sel,
                reg_we:     ex_mem.reg_we
            };
    end

    always_comb
    begin
        case (mem_wb.wb_sel)
            wb_mem:  wb_data = mem_wb.load_data;
            wb_link: wb_data = mem_wb.pc + 32'd4;  // bl return address
            default: wb_data = mem_wb.alu_result;
        endcase
    end

    assign wb = '{we: mem_wb.valid && mem_wb.reg_we, rd: mem_wb.rd, data: wb_data, pc: mem_wb.pc};

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  id_ex_t    id_ex,
    input  wb_t       wb,
    output redirect_t redirect,
    output reg_addr_t ex_load_rd,
    output logic      data_en,
    output strobe_t   data_we,
    output word_t     data_addr,
    output word_t     data_wdata,
    output ex_mem_t   ex_mem
);

    word_t   mem_value;  // result the memory stage will write back
    word_t   src_j;
    word_t   src_k;
    word_t   alu_b;
    word_t   alu_result;
    logic    taken;
    logic    is_load;
    logic    is_store;
    ex_mem_t ex_mem_next;

    // memory stage first, then writeback, then the register file value
    function automatic word_t forward(reg_addr_t num, word_t rf_value, ex_mem_t mem_stage,
                                      word_t mem_data, wb_t wb_bus);
        if (num == '0)
            return '0;
        if (mem_stage.valid && mem_stage.reg_we && mem_stage.rd == num)
            return mem_data;
        if (wb_bus.we && wb_bus.rd == num)
            return wb_bus.data;
        return rf_value;
    endfunction

    assign mem_value = (ex_mem.wb_sel == wb_link) ? ex_mem.pc + 32'd4 : ex_mem.alu_result;

    always_comb
    begin
        src_j = forward(id_ex.rj, id_ex.rj_data, ex_mem, mem_value, wb);
        src_k = forward(id_ex.rk, id_ex.rk_data, ex_mem, mem_value, wb);
    end

    assign alu_b = id_ex.b_imm ? id_ex.imm : src_k;

    always_comb
    begin
        case (id_ex.alu_op)
            alu_add:  alu_result = src_j + alu_b;
            alu_sub:  alu_result = src_j - alu_b;
            alu_and:  alu_result = src_j & alu_b;
            alu_or:   alu_result = src_j | alu_b;
            alu_xor:  alu_result = src_j ^ alu_b;
            alu_slt:  alu_result = word_t'($signed(src_j) < $signed(alu_b));
            alu_sltu: alu_result = word_t'(src_j < alu_b);
            default:  alu_result = alu_b;  // lu12i.w
        endcase
    end

    always_comb
    begin
        case (id_ex.branch_op)
            br_beq:    taken = src_j == src_k;
            br_bne:    taken = src_j != src_k;
            br_always: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign redirect = '{taken: id_ex.valid && taken, target: id_ex.branch_target};

    assign is_load  = id_ex.mem_op inside {mem_ld_w, mem_ld_b, mem_ld_bu};
    assign is_store = id_ex.mem_op inside {mem_st_w, mem_st_b};

    assign ex_load_rd = (id_ex.valid && is_load) ? id_ex.rd : '0;

    // sram request goes out now, data comes back in memory
    assign data_en   = id_ex.valid && (is_load || is_store);
    assign data_addr = alu_result;

    always_comb
    begin
        data_we    = '0;
        data_wdata = src_k;
        if (id_ex.valid && id_ex.mem_op == mem_st_w)
            data_we = 4'hf;
        else if (id_ex.valid && id_ex.mem_op == mem_st_b)
        begin
            data_we    = strobe_t'(1) << alu_result[1:0];  // one lane
            data_wdata = {4{src_k[7:0]}};
        end
    end

    assign ex_mem_next = '{
        valid:      id_ex.valid,
        pc:         id_ex.pc,
        rd:         id_ex.rd,
        alu_result: alu_result,
        store_data: src_k,
        mem_op:     id_ex.mem_op,
        wb_sel:     id_ex.wb_sel,
        reg_we:     id_ex.reg_we
    };

    always_ff @(posedge clk)
    begin
        if (!reset)
            ex_mem <= '0;
        else
            ex_mem <= ex_mem_next;
    end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  if_id_t    if_id,
    input  wb_t       wb,
    input  redirect_t redirect,
    input  reg_addr_t ex_load_rd,
    output logic      stall,
    output id_ex_t    id_ex
);

    word_t      inst;
    word_t      si12;
    word_t      si20;
    word_t      offs16;
    word_t      offs26;
    alu_op_t    alu_op;
    logic       b_imm;
    branch_op_t branch_op;
    mem_op_t    mem_op;
    wb_sel_t    wb_sel;
    logic       writes_rd;
    logic       use_rj;
    logic       use_rk;
    logic       rk_from_rd;
    logic       is_3r;
    logic       is_2ri12;
    word_t      imm;
    word_t      offset;
    reg_addr_t  dest;
    reg_addr_t  rj_num;
    reg_addr_t  rk_num;
    word_t      rj_data;
    word_t      rk_data;
    id_ex_t     id_ex_next;

    assign inst   = if_id.inst;
    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign si20   = {inst[24:5], 12'b0};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb
    begin
        alu_op     = alu_add;
        b_imm      = 1'b0;
        branch_op  = br_none;
        mem_op     = mem_none;
        wb_sel     = wb_alu;
        writes_rd  = 1'b0;
        use_rj     = 1'b0;
        use_rk     = 1'b0;
        rk_from_rd = 1'b0;
        is_3r      = 1'b0;
        is_2ri12   = 1'b0;
        imm        = si12;
        offset     = offs16;
        dest       = inst[4:0];
        if (if_id.valid)
        begin
            is_3r = 1'b1;
            case (inst[31:15])
                op_add_w: alu_op = alu_add;
                op_sub_w: alu_op = alu_sub;
                op_slt:   alu_op = alu_slt;
                op_sltu:  alu_op = alu_sltu;
                op_and:   alu_op = alu_and;
                op_or:    alu_op = alu_or;
                op_xor:   alu_op = alu_xor;
                default:  is_3r = 1'b0;
            endcase
            is_2ri12 = 1'b1;
            case (inst[31:22])
                op_addi_w: writes_rd = 1'b1;
                op_ld_w:   mem_op = mem_ld_w;
                op_ld_b:   mem_op = mem_ld_b;
                op_ld_bu:  mem_op = mem_ld_bu;
                op_st_w:   mem_op = mem_st_w;
                op_st_b:   mem_op = mem_st_b;
                default:   is_2ri12 = 1'b0;
            endcase
            if (inst[31:25] == op_lu12i_w)
            begin
                alu_op    = alu_lui;
                b_imm     = 1'b1;
                imm       = si20;
                writes_rd = 1'b1;
            end
            case (inst[31:26])
                op_b:   branch_op = br_always;
                op_bl:
                begin
                    branch_op = br_always;
                    writes_rd = 1'b1;
                    wb_sel    = wb_link;
                    dest      = reg_addr_t'(1);  // ra
                end
                op_beq: branch_op = br_beq;
                op_bne: branch_op = br_bne;
                default: ;
            endcase
            if (is_3r)
            begin
                writes_rd = 1'b1;
                use_rj    = 1'b1;
                use_rk    = 1'b1;
            end
            if (is_2ri12)
            begin
                b_imm  = 1'b1;
                use_rj = 1'b1;
            end
            if (mem_op inside {mem_ld_w, mem_ld_b, mem_ld_bu})
            begin
                writes_rd = 1'b1;
                wb_sel    = wb_mem;
            end
            // stores and compares read the rd field as a source
            if (mem_op inside {mem_st_w, mem_st_b} || branch_op inside {br_beq, br_bne})
            begin
                use_rj     = use_rj || branch_op != br_none;
                use_rk     = 1'b1;
                rk_from_rd = 1'b1;
            end
            if (branch_op == br_always)
                offset = offs26;
        end
    end

    assign rj_num = use_rj ? inst[9:5] : '0;
    assign rk_num = !use_rk ? '0 : rk_from_rd ? inst[4:0] : inst[14:10];

    reg_file u_reg_file
    (
        .clk   (clk),
        .reset (reset),
        .ra1   (rj_num),
        .ra2   (rk_num),
        .rd1   (rj_data),
        .rd2   (rk_data),
        .wb    (wb)
    );

    // load in execute feeding a source here
    assign stall = ex_load_rd != '0 && (ex_load_rd == rj_num || ex_load_rd == rk_num);

    assign id_ex_next = '{
        valid:         if_id.valid,
        pc:            if_id.pc,
        rj:            rj_num,
        rk:            rk_num,
        rd:            dest,
        rj_data:       rj_data,
        rk_data:       rk_data,
        imm:           imm,
        alu_op:        alu_op,
        b_imm:         b_imm,
        branch_op:     branch_op,
        branch_target: if_id.pc + offset,
        mem_op:        mem_op,
        wb_sel:        wb_sel,
        reg_we:        writes_rd && dest != '0
    };

    always_ff @(posedge clk)
    begin
        if (!reset)
            id_ex <= '0;
        else if (stall || redirect.taken)
            id_ex <= '0;  // bubble
        else
            id_ex <= id_ex_next;
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    output word_t     rd1,
    output word_t     rd2,
    input  wb_t       wb
);

    word_t regs [1:31];  // r0 has no storage

    always_ff @(posedge clk)
    begin
        if (reset && wb.we && wb.rd != '0)
            regs[wb.rd] <= wb.data;
    end

    // same-cycle write is visible to the reader
    assign rd1 = (ra1 == '0) ? '0 : (wb.we && wb.rd == ra1) ? wb.data : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (wb.we && wb.rd == ra2) ? wb.data : regs[ra2];

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  redirect_t redirect,
    output word_t     inst_addr,
    input  word_t     inst_rdata,
    output if_id_t    if_id
);

    word_t pc;
    word_t next_pc;

    always_comb
    begin
        if (redirect.taken)
            next_pc = redirect.target;  // branch from execute wins
        else if (stall)
            next_pc = pc;
        else
            next_pc = pc + 32'd4;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
            pc <= reset_pc;
        else
            pc <= next_pc;
    end

    assign inst_addr = pc;  // instruction port reads combinationally

    always_ff @(posedge clk)
    begin
        if (!reset)
            if_id <= '0;
        else if (redirect.taken)
            if_id <= '0;  // wrong-path fetch dropped
        else if (!stall)
            if_id <= '{valid: 1'b1, pc: pc, inst: inst_rdata};
    end

endmodule

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [31:0] reset_pc = 32'h1c000000;

    // 3R group, matched on inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_sltu  = 17'h00025;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // 2RI12 group, matched on inst[31:22]
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_b   = 10'h0a0;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_b   = 10'h0a4;
    localparam logic [9:0] op_st_w   = 10'h0a6;
    localparam logic [9:0] op_ld_bu  = 10'h0a8;

    localparam logic [6:0] op_lu12i_w = 7'h0a;  // inst[31:25]

    // branches, matched on inst[31:26]
    localparam logic [5:0] op_b   = 6'h14;
    localparam logic [5:0] op_bl  = 6'h15;
    localparam logic [5:0] op_beq = 6'h16;
    localparam logic [5:0] op_bne = 6'h17;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [3:0]            strobe_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_lui     // passes operand b through
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_link
    } wb_sel_t;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_always
    } branch_op_t;

    typedef enum logic [2:0] {
        mem_none,
        mem_ld_w,
        mem_ld_b,
        mem_ld_bu,
        mem_st_w,
        mem_st_b
    } mem_op_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        reg_addr_t  rj;             // zero when not read
        reg_addr_t  rk;             // second source, may come from the rd field
        reg_addr_t  rd;
        word_t      rj_data;
        word_t      rk_data;
        word_t      imm;
        alu_op_t    alu_op;
        logic       b_imm;
        branch_op_t branch_op;
        word_t      branch_target;
        mem_op_t    mem_op;
        wb_sel_t    wb_sel;
        logic       reg_we;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     alu_result;
        word_t     store_data;
        mem_op_t   mem_op;
        wb_sel_t   wb_sel;
        logic      reg_we;
    } ex_mem_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
        word_t     pc;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire
